// ==== sources.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_ctrl.sv
src/main_cache.sv
src/victim_cache.sv
src/mshr_table.sv
src/dcache.sv
verif/mem_model.sv
verif/dcache_tb.sv

// ==== src/dcache.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  dcache_request,
    input  dcache_pkg::mem_tag_t         mem_response,
    input  dcache_pkg::mem_tag_t         mem_tag,
    input  dcache_pkg::block_t           mem_data,
    output logic                         stall,
    output dcache_pkg::dcache_response_t dcache_response,
    output dcache_pkg::bus_cmd_t         mem_command,
    output dcache_pkg::mem_addr_t        mem_addr,
    output dcache_pkg::block_t           mem_data_out
);
    import dcache_pkg::*;

    logic            accept;
    logic            main_hit;
    logic            vc_hit;
    logic            wb_pending;
    logic            mshr_free;
    logic            alloc_read;
    logic            fill_done;
    block_t          main_block;
    block_t          vc_block;
    block_t          resp_block;
    evict_line_t     main_evict;
    evict_line_t     vc_evict;
    fill_t           fill;
    dcache_request_t wait_request;

    assign accept = dcache_request.valid && !stall;

    dcache_ctrl ctrl_i (
        .clock, .reset,
        .request      (dcache_request),
        .main_hit, .vc_hit, .wb_pending, .mshr_free, .fill,
        .stall, .alloc_read, .wait_request, .fill_done
    );

    main_cache main_i (
        .clock, .reset,
        .request      (dcache_request),
        .accept, .wait_request, .fill, .fill_done,
        .hit          (main_hit),
        .hit_block    (main_block),
        .evict        (main_evict)
    );

    victim_cache victim_i (
        .clock, .reset,
        .request      (dcache_request),
        .accept,
        .evict_in     (main_evict),
        .hit          (vc_hit),
        .hit_block    (vc_block),
        .evict_out    (vc_evict)
    );

    mshr_table mshr_i (
        .clock, .reset,
        .alloc_read, .wait_request, .vc_evict,
        .mem_response, .mem_tag, .mem_data,
        .mem_command, .mem_addr, .mem_data_out, .fill,
        .wb_pending, .mshr_free
    );

    always_comb begin
        if (fill_done)
            resp_block = fill.block;   // miss completes from the returning line
        else if (main_hit)
            resp_block = main_block;
        else
            resp_block = vc_block;
    end

    // wait_request is the live request in READY, so it fits both cases
    always_ff @(posedge clock) begin
        dcache_response.reg_data <= extract_load(resp_block, wait_request.addr[`DC_BO-1:0],
                                                 wait_request.size);
        if (reset)
            dcache_response.valid <= 1'b0;
        else
            dcache_response.valid <= fill_done || (accept && (main_hit || vc_hit));
    end

endmodule

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::dcache_request_t request,
    input  logic                        main_hit,
    input  logic                        vc_hit,
    input  logic                        wb_pending,
    input  logic                        mshr_free,
    input  dcache_pkg::fill_t           fill,
    output logic                        stall,
    output logic                        alloc_read,
    output dcache_pkg::dcache_request_t wait_request,
    output logic                        fill_done
);
    import dcache_pkg::*;

    dc_state_t       state;
    dc_state_t       next_state;
    dcache_request_t held_request;
    logic            miss;
    logic            can_alloc;

    assign miss      = request.valid && !main_hit && !vc_hit;
    assign can_alloc = !wb_pending && mshr_free;
    assign stall     = state != READY;

    // the live request until a miss has been latched
    assign wait_request = (state == READY) ? request : held_request;

    assign fill_done = state == WAIT && fill.valid &&
                       fill.line_addr == held_request.addr[`XLEN-1:`DC_BO];

    always_comb begin
        next_state = state;
        alloc_read = 1'b0;
        case (state)
            READY: begin
                if (miss) begin
                    next_state = can_alloc ? WAIT : WAIT_MSHR;
                    alloc_read = can_alloc;
                end
            end
            WAIT_MSHR: begin
                if (can_alloc) begin   // write-back issued and a read entry free
                    next_state = WAIT;
                    alloc_read = 1'b1;
                end
            end
            WAIT:    if (fill_done) next_state = READY;
            default: next_state = READY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= READY;
        else
            state <= next_state;
        if (state == READY && miss)
            held_request <= request;
    end

    // one read per miss, so every returning line belongs to the waiting request
    assert property (@(posedge clock) disable iff (reset) fill.valid |-> fill_done)
        else $error("fill arrived with no matching miss waiting");

endmodule

// ==== src/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and block geometry
`define XLEN          32
`define DC_BLK_BITS   64
`define DC_BO         3     // byte offset inside a block

// direct-mapped main cache
`define N_CL          8
`define N_IDX_BITS    3
`define DC_TAG_LEN    26    // XLEN - N_IDX_BITS - DC_BO

// fully associative victim cache
`define N_VC_CL       4

// outstanding memory traffic
`define N_MSHR        4
`define MEM_TAG_BITS  4

// memory model response delay in cycles
`define MEM_LATENCY   6

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`XLEN-1:0]            mem_addr_t;
    typedef logic [`DC_BLK_BITS-1:0]     block_t;
    typedef logic [`XLEN-1:0]            reg_data_t;
    typedef logic [`DC_TAG_LEN-1:0]      cl_tag_t;
    typedef logic [`XLEN-`DC_BO-1:0]     vc_tag_t;   // full line address
    typedef logic [`MEM_TAG_BITS-1:0]    mem_tag_t;
    typedef logic [$clog2(`N_VC_CL)-1:0] lru_t;

    typedef enum logic [1:0] {MEM_READ, MEM_WRITE} mem_op_t;
    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;
    typedef enum logic [1:0] {READY, WAIT_MSHR, WAIT} dc_state_t;

    typedef struct packed {
        logic      valid;
        mem_op_t   mem_op;
        mem_size_t size;
        mem_addr_t addr;
        reg_data_t write_content;
    } dcache_request_t;

    typedef struct packed {
        logic      valid;
        reg_data_t reg_data;
    } dcache_response_t;

    typedef struct packed {
        logic    valid;
        logic    dirty;
        cl_tag_t cl_tag;
        block_t  block;
    } cache_line_t;

    typedef struct packed {
        logic    valid;
        logic    dirty;
        lru_t    lru;
        vc_tag_t vc_tag;
        block_t  block;
    } vc_line_t;

    // main to victim, and victim to the MSHR
    typedef struct packed {
        logic    valid;
        logic    dirty;
        vc_tag_t line_addr;
        block_t  block;
    } evict_line_t;

    typedef struct packed {
        logic    valid;
        vc_tag_t line_addr;
        block_t  block;
    } fill_t;

    function automatic block_t merge_store(block_t blk, logic [`DC_BO-1:0] offset,
                                           mem_size_t size, reg_data_t data);
        block_t merged;
        merged = blk;
        case (size)
            BYTE:    merged[offset*8 +: 8] = data[7:0];
            HALF:    merged[offset[`DC_BO-1:1]*16 +: 16] = data[15:0];
            default: merged[offset[`DC_BO-1]*32 +: 32] = data;
        endcase
        return merged;
    endfunction

    // loads are zero-extended
    function automatic reg_data_t extract_load(block_t blk, logic [`DC_BO-1:0] offset,
                                               mem_size_t size);
        reg_data_t word;
        word = '0;
        case (size)
            BYTE:    word[7:0] = blk[offset*8 +: 8];
            HALF:    word[15:0] = blk[offset[`DC_BO-1:1]*16 +: 16];
            default: word = blk[offset[`DC_BO-1]*32 +: 32];
        endcase
        return word;
    endfunction

endpackage

// ==== src/main_cache.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module main_cache (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::dcache_request_t request,
    input  logic                        accept,
    input  dcache_pkg::dcache_request_t wait_request,
    input  dcache_pkg::fill_t           fill,
    input  logic                        fill_done,
    output logic                        hit,
    output dcache_pkg::block_t          hit_block,
    output dcache_pkg::evict_line_t     evict
);
    import dcache_pkg::*;

    cache_line_t            lines [`N_CL];
    logic [`N_IDX_BITS-1:0] req_idx;
    logic [`N_IDX_BITS-1:0] fill_idx;
    logic                   fill_store;
    block_t                 fill_block;

    assign req_idx  = request.addr[`N_IDX_BITS+`DC_BO-1:`DC_BO];
    assign fill_idx = fill.line_addr[`N_IDX_BITS-1:0];

    assign hit = request.valid && lines[req_idx].valid &&
                 lines[req_idx].cl_tag == request.addr[`XLEN-1:`XLEN-`DC_TAG_LEN];
    assign hit_block = lines[req_idx].block;

    // store that missed lands in the fresh block
    assign fill_store = fill_done && wait_request.mem_op == MEM_WRITE;
    assign fill_block = fill_store ?
        merge_store(fill.block, wait_request.addr[`DC_BO-1:0], wait_request.size,
                    wait_request.write_content) : fill.block;

    // old occupant goes to the victim cache in the fill cycle
    always_comb begin
        evict.valid     = fill.valid && lines[fill_idx].valid;
        evict.dirty     = lines[fill_idx].dirty;
        evict.line_addr = {lines[fill_idx].cl_tag, fill_idx};
        evict.block     = lines[fill_idx].block;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `N_CL; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (fill.valid) begin
            lines[fill_idx].valid  <= 1'b1;
            lines[fill_idx].dirty  <= fill_store;   // clean unless a store merged
            lines[fill_idx].cl_tag <= fill.line_addr[`XLEN-`DC_BO-1:`N_IDX_BITS];
            lines[fill_idx].block  <= fill_block;
        end else if (accept && hit && request.mem_op == MEM_WRITE) begin
            lines[req_idx].dirty <= 1'b1;
            lines[req_idx].block <= merge_store(lines[req_idx].block,
                                                request.addr[`DC_BO-1:0], request.size,
                                                request.write_content);
        end
    end

endmodule

// ==== src/mshr_table.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module mshr_table (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        alloc_read,
    input  dcache_pkg::dcache_request_t wait_request,
    input  dcache_pkg::evict_line_t     vc_evict,
    input  dcache_pkg::mem_tag_t        mem_response,
    input  dcache_pkg::mem_tag_t        mem_tag,
    input  dcache_pkg::block_t          mem_data,
    output dcache_pkg::bus_cmd_t        mem_command,
    output dcache_pkg::mem_addr_t       mem_addr,
    output dcache_pkg::block_t          mem_data_out,
    output dcache_pkg::fill_t           fill,
    output logic                        wb_pending,
    output logic                        mshr_free
);
    import dcache_pkg::*;

    localparam int IW = $clog2(`N_MSHR);

    logic     ent_valid [`N_MSHR];
    logic     ent_write [`N_MSHR];   // write-back or read
    mem_tag_t ent_tag   [`N_MSHR];   // zero until memory accepts
    vc_tag_t  ent_line  [`N_MSHR];
    block_t   ent_data  [`N_MSHR];

    logic [IW-1:0] free_idx;
    logic [IW-1:0] issue_idx;
    logic [IW-1:0] ret_idx;
    logic          issue;
    logic          ret_hit;

    always_comb begin
        free_idx   = '0;
        mshr_free  = 1'b0;
        wb_pending = 1'b0;
        issue      = 1'b0;
        issue_idx  = '0;
        for (int i = `N_MSHR-1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx  = IW'(i);
                mshr_free = 1'b1;
            end
            if (ent_valid[i] && ent_write[i] && wait_request.valid &&
                ent_line[i] == wait_request.addr[`XLEN-1:`DC_BO])
                wb_pending = 1'b1;
            if (ent_valid[i] && !ent_write[i] && ent_tag[i] == '0) begin
                issue     = 1'b1;
                issue_idx = IW'(i);
            end
        end
        // write-backs override any read candidate
        for (int i = `N_MSHR-1; i >= 0; i--) begin
            if (ent_valid[i] && ent_write[i] && ent_tag[i] == '0) begin
                issue     = 1'b1;
                issue_idx = IW'(i);
            end
        end
    end

    always_comb begin
        ret_hit = 1'b0;
        ret_idx = '0;
        for (int i = 0; i < `N_MSHR; i++) begin
            if (ent_valid[i] && !ent_write[i] && mem_tag != '0 && ent_tag[i] == mem_tag) begin
                ret_hit = 1'b1;
                ret_idx = IW'(i);
            end
        end
    end

    assign fill.valid     = ret_hit;
    assign fill.line_addr = ent_line[ret_idx];
    assign fill.block     = mem_data;

    assign mem_command  = !issue ? BUS_NONE : (ent_write[issue_idx] ? BUS_STORE : BUS_LOAD);
    assign mem_addr     = {ent_line[issue_idx], {`DC_BO{1'b0}}};
    assign mem_data_out = (issue && ent_write[issue_idx]) ? ent_data[issue_idx] : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `N_MSHR; i++)
                ent_valid[i] <= 1'b0;
        end else begin
            if (ret_hit)
                ent_valid[ret_idx] <= 1'b0;
            if (issue && mem_response != '0) begin
                if (ent_write[issue_idx])
                    ent_valid[issue_idx] <= 1'b0;   // stores are done once accepted
                else
                    ent_tag[issue_idx] <= mem_response;
            end
            if (vc_evict.valid) begin
                ent_valid[free_idx] <= 1'b1;
                ent_write[free_idx] <= 1'b1;
                ent_tag[free_idx]   <= '0;
                ent_line[free_idx]  <= vc_evict.line_addr;
                ent_data[free_idx]  <= vc_evict.block;
            end else if (alloc_read) begin
                ent_valid[free_idx] <= 1'b1;
                ent_write[free_idx] <= 1'b0;
                ent_tag[free_idx]   <= '0;
                ent_line[free_idx]  <= wait_request.addr[`XLEN-1:`DC_BO];
            end
        end
    end

    // every tag that memory returns belongs to an outstanding read
    assert property (@(posedge clock) disable iff (reset) mem_tag != '0 |-> ret_hit)
        else $error("memory tag %0d matched no outstanding read", mem_tag);

endmodule

// ==== src/victim_cache.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module victim_cache (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::dcache_request_t request,
    input  logic                        accept,
    input  dcache_pkg::evict_line_t     evict_in,
    output logic                        hit,
    output dcache_pkg::block_t          hit_block,
    output dcache_pkg::evict_line_t     evict_out
);
    import dcache_pkg::*;

    localparam int VW = $clog2(`N_VC_CL);

    vc_line_t                    lines [`N_VC_CL];
    logic [VW:0]                 n_valid;   // occupied slots
    logic                        full;
    logic [`N_VC_CL-1:0]         valid_vec;
    logic [VW-1:0]               hit_idx;
    logic [VW-1:0]               free_idx;
    logic [VW-1:0]               lru_idx;
    logic [VW-1:0]               ins_idx;
    lru_t                        min_lru;

    assign full = n_valid == `N_VC_CL;

    always_comb begin
        hit       = 1'b0;
        hit_idx   = '0;
        free_idx  = '0;
        lru_idx   = '0;
        min_lru   = '1;
        for (int i = `N_VC_CL-1; i >= 0; i--) begin
            valid_vec[i] = lines[i].valid;
            if (!lines[i].valid)
                free_idx = VW'(i);   // lowest free slot wins
        end
        for (int i = 0; i < `N_VC_CL; i++) begin
            if (lines[i].valid && lines[i].vc_tag == request.addr[`XLEN-1:`DC_BO] &&
                request.valid) begin
                hit     = 1'b1;
                hit_idx = VW'(i);
            end
            if (lines[i].lru < min_lru) begin
                min_lru = lines[i].lru;
                lru_idx = VW'(i);
            end
        end
    end

    assign hit_block = lines[hit_idx].block;
    assign ins_idx   = full ? lru_idx : free_idx;

    // clean lines are simply dropped
    always_comb begin
        evict_out.valid     = evict_in.valid && full && lines[lru_idx].dirty;
        evict_out.dirty     = 1'b1;
        evict_out.line_addr = lines[lru_idx].vc_tag;
        evict_out.block     = lines[lru_idx].block;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            n_valid <= '0;
            for (int i = 0; i < `N_VC_CL; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
                lines[i].lru   <= '0;
            end
        end else begin
            if (accept && hit) begin
                for (int i = 0; i < `N_VC_CL; i++) begin
                    if (VW'(i) == hit_idx)
                        lines[i].lru <= '1;
                    else if (lines[i].lru != '0)
                        lines[i].lru <= lines[i].lru - 1'b1;
                end
                if (request.mem_op == MEM_WRITE) begin
                    lines[hit_idx].dirty <= 1'b1;
                    lines[hit_idx].block <= merge_store(lines[hit_idx].block,
                                                        request.addr[`DC_BO-1:0],
                                                        request.size, request.write_content);
                end
            end
            if (evict_in.valid) begin
                lines[ins_idx].valid  <= 1'b1;
                lines[ins_idx].dirty  <= evict_in.dirty;
                lines[ins_idx].lru    <= '0;
                lines[ins_idx].vc_tag <= evict_in.line_addr;
                lines[ins_idx].block  <= evict_in.block;
                if (!full)
                    n_valid <= n_valid + 1'b1;
            end
        end
    end

    // occupancy count and valid bits must agree
    assert property (@(posedge clock) disable iff (reset) full |-> &valid_vec)
        else $error("victim cache counted full with an invalid line");

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_TESTS         = 24;
    localparam int WATCHDOG_CYCLES = 4 + N_TESTS * (`MEM_LATENCY + 20);

    typedef struct packed {
        mem_op_t    op;
        mem_size_t  size;
        mem_addr_t  addr;
        logic       hit;       // must answer in the next cycle
        logic [3:0] hold;      // cycles of memory back-pressure
        mem_addr_t  wb_addr;   // expected write-back line or zero
    } test_entry_t;

    logic             clock = 1'b0;
    logic             reset;
    logic             busy;
    dcache_request_t  request;
    logic             stall;
    dcache_response_t response;
    bus_cmd_t         mem_command;
    mem_addr_t        mem_addr;
    block_t           mem_data_out;
    mem_tag_t         mem_response;
    mem_tag_t         mem_tag;
    block_t           mem_data;

    test_entry_t tests  [N_TESTS];
    string       names  [N_TESTS];
    int          n_tests = 0;
    block_t      shadow [256];
    logic [31:0] lfsr = 32'h2285;

    always #2 clock = ~clock;

    dcache dcache_i (
        .clock, .reset,
        .dcache_request  (request),
        .mem_response, .mem_tag, .mem_data,
        .stall,
        .dcache_response (response),
        .mem_command, .mem_addr, .mem_data_out
    );

    mem_model memory (
        .clock, .reset, .busy,
        .command  (mem_command),
        .addr     (mem_addr),
        .wdata    (mem_data_out),
        .response (mem_response),
        .tag      (mem_tag),
        .rdata    (mem_data)
    );

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        report_problem($sformatf("** Error %s: expected %0h, actual %0h",
                                 name, expected, actual));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_random(output reg_data_t word);
        for (int b = 0; b < 32; b++) begin
            word[b] = lfsr[0];   // one step per bit
            lfsr    = lfsr_step(lfsr);
        end
    endtask

    function automatic int size_bytes(input mem_size_t size);
        return (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
    endfunction

    // little-endian bytes within a 64-bit line
    task automatic shadow_store(input mem_addr_t addr, input mem_size_t size,
                                input reg_data_t data);
        block_t blk;
        blk = shadow[addr[10:3]];
        for (int k = 0; k < size_bytes(size); k++)
            blk[8*(addr[2:0]+k) +: 8] = data[8*k +: 8];
        shadow[addr[10:3]] = blk;
    endtask

    function automatic reg_data_t shadow_load(input mem_addr_t addr, input mem_size_t size);
        block_t    blk;
        reg_data_t word;
        blk  = shadow[addr[10:3]];
        word = '0;   // zero-extended
        for (int k = 0; k < size_bytes(size); k++)
            word[8*k +: 8] = blk[8*(addr[2:0]+k) +: 8];
        return word;
    endfunction

    task automatic add_test(input string name, input mem_op_t op, input mem_size_t size,
                            input mem_addr_t addr, input logic hit, input int hold,
                            input mem_addr_t wb_addr);
        test_entry_t t;
        t.op      = op;
        t.size    = size;
        t.addr    = addr;
        t.hit     = hit;
        t.hold    = 4'(hold);
        t.wb_addr = wb_addr;
        tests[n_tests] = t;
        names[n_tests] = name;
        n_tests++;
    endtask

    // the write-back shows up right after the fill that pushed it out
    task automatic check_writeback(input string name, input mem_addr_t wb_addr);
        int waited;
        waited = 0;
        while (!(mem_command == BUS_STORE && mem_response != '0)) begin
            waited++;
            assert (waited < 8) else report_problem({name, ": no write-back reached memory"});
            @(negedge clock);
        end
        assert (mem_addr == wb_addr) else report_mismatch(name, wb_addr, mem_addr);
        assert (mem_data_out == shadow[wb_addr[10:3]])
            else report_mismatch(name, shadow[wb_addr[10:3]], mem_data_out);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        report_problem("watchdog expired before the test table finished");
    end

    initial begin : run
        test_entry_t t;
        reg_data_t   data;
        reg_data_t   expected;
        int          waited;
        reset   = 1'b1;
        busy    = 1'b0;
        request = '0;
        add_test("ld_miss_w",   MEM_READ,  WORD, 32'h100, 1'b0, 0, 32'h0);
        add_test("ld_hit_b",    MEM_READ,  BYTE, 32'h103, 1'b1, 0, 32'h0);
        add_test("ld_hit_h",    MEM_READ,  HALF, 32'h106, 1'b1, 0, 32'h0);
        add_test("st_hit_b",    MEM_WRITE, BYTE, 32'h101, 1'b1, 0, 32'h0);
        add_test("st_hit_h",    MEM_WRITE, HALF, 32'h104, 1'b1, 0, 32'h0);
        add_test("ld_merge_lo", MEM_READ,  WORD, 32'h100, 1'b1, 0, 32'h0);
        add_test("ld_merge_hi", MEM_READ,  WORD, 32'h104, 1'b1, 0, 32'h0);
        add_test("st_miss_w",   MEM_WRITE, WORD, 32'h20C, 1'b0, 0, 32'h0);
        add_test("ld_stmiss_w", MEM_READ,  WORD, 32'h20C, 1'b1, 0, 32'h0);
        add_test("ld_stmiss_b", MEM_READ,  BYTE, 32'h20D, 1'b1, 0, 32'h0);
        add_test("ld_stmiss_h", MEM_READ,  HALF, 32'h208, 1'b1, 0, 32'h0);
        add_test("st_vc_a",     MEM_WRITE, WORD, 32'h014, 1'b0, 0, 32'h0);
        add_test("ld_conflict", MEM_READ,  WORD, 32'h050, 1'b0, 0, 32'h0);   // pushes 0x010 out
        add_test("ld_vc_a",     MEM_READ,  WORD, 32'h014, 1'b1, 0, 32'h0);
        add_test("st_vc_b",     MEM_WRITE, BYTE, 32'h012, 1'b1, 0, 32'h0);
        add_test("ld_vc_h",     MEM_READ,  HALF, 32'h012, 1'b1, 0, 32'h0);
        add_test("st_ovf_0",    MEM_WRITE, WORD, 32'h018, 1'b0, 0, 32'h0);
        add_test("st_ovf_1",    MEM_WRITE, WORD, 32'h058, 1'b0, 0, 32'h0);
        add_test("st_ovf_2",    MEM_WRITE, WORD, 32'h098, 1'b0, 0, 32'h0);
        add_test("st_ovf_3",    MEM_WRITE, WORD, 32'h0D8, 1'b0, 0, 32'h0);
        add_test("st_ovf_4",    MEM_WRITE, WORD, 32'h118, 1'b0, 0, 32'h018);
        add_test("ld_reload",   MEM_READ,  WORD, 32'h018, 1'b0, 0, 32'h0D8);
        add_test("ld_bp",       MEM_READ,  WORD, 32'h7F0, 1'b0, 8, 32'h0);
        add_test("ld_bp_hit",   MEM_READ,  BYTE, 32'h7F5, 1'b1, 0, 32'h0);

        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < 256; i++)
            shadow[i] = memory.storage[i];   // reset image of the memory

        for (int n = 0; n < N_TESTS; n++) begin
            t    = tests[n];
            data = '0;
            if (t.op == MEM_WRITE) begin
                draw_random(data);
                shadow_store(t.addr, t.size, data);
            end
            expected              = shadow_load(t.addr, t.size);
            request.valid         = 1'b1;
            request.mem_op        = t.op;
            request.size          = t.size;
            request.addr          = t.addr;
            request.write_content = data;
            busy                  = t.hold != 0;
            for (int c = 0; c < t.hold; c++) begin
                @(negedge clock);
                assert (stall && !response.valid)
                    else report_problem({names[n], ": cache went on while memory refused"});
            end
            busy   = 1'b0;
            waited = 0;
            do begin
                @(negedge clock);
                waited++;
            end while (!response.valid);
            request.valid = 1'b0;
            assert (!stall)
                else report_problem({names[n], ": stall still high with the response"});
            if (t.hit) begin
                assert (waited == 1) else report_mismatch(names[n], 1, waited);
            end else begin
                assert (waited > 1)
                    else report_problem({names[n], ": miss answered in the next cycle"});
            end
            if (t.op == MEM_READ)
                assert (response.reg_data == expected)
                    else report_mismatch(names[n], expected, response.reg_data);
            if (t.wb_addr != '0)
                check_writeback(names[n], t.wb_addr);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps
`include "dcache_defs.svh"

module mem_model (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  busy,       // refuses every command while high
    input  dcache_pkg::bus_cmd_t  command,
    input  dcache_pkg::mem_addr_t addr,
    input  dcache_pkg::block_t    wdata,
    output dcache_pkg::mem_tag_t  response,
    output dcache_pkg::mem_tag_t  tag,
    output dcache_pkg::block_t    rdata
);
    import dcache_pkg::*;

    localparam int DEPTH = `MEM_LATENCY - 1;   // plus the output register

    block_t     storage  [256];   // one entry per line of a 2 KB window
    mem_tag_t   next_tag;
    mem_tag_t   pipe_tag [DEPTH];
    logic [7:0] pipe_idx [DEPTH];

    initial begin
        for (int i = 0; i < 256; i++)
            storage[i] = {32'hC0DE_0000 | 32'(i), 32'(i) * 32'h9E37_79B9};
    end

    assign response = (command != BUS_NONE && !busy) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'h1;
            tag      <= '0;
            for (int i = 0; i < DEPTH; i++)
                pipe_tag[i] <= '0;
        end else begin
            for (int i = DEPTH-1; i > 0; i--) begin
                pipe_tag[i] <= pipe_tag[i-1];
                pipe_idx[i] <= pipe_idx[i-1];
            end
            pipe_tag[0] <= (command == BUS_LOAD && response != '0) ? response : '0;
            pipe_idx[0] <= addr[10:3];
            tag   <= pipe_tag[DEPTH-1];
            rdata <= storage[pipe_idx[DEPTH-1]];
            if (response != '0)
                next_tag <= (next_tag == 4'hF) ? 4'h1 : next_tag + 1'b1;   // zero means refused
            if (command == BUS_STORE && response != '0)
                storage[addr[10:3]] <= wdata;
        end
    end

endmodule
